//--- hw/axi4_chan_slice.sv
// Channel register slice
module axi4_chan_slice #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	logic full;
	logic ready_en;
	payload_t data_q;

	// ready_en keeps the input closed for the first cycle out of reset
	assign in_ready = ready_en && (!full || out_ready);
	assign out_valid = full;
	assign out_data = data_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
			ready_en <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			// a new entry may replace the one being taken in the same cycle
			if (in_valid && in_ready) begin
				full <= 1'b1;
			end else if (out_ready) begin
				full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	// the entry offered downstream must hold until it is taken
	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- hw/axi4_l1_mem_subsys.sv
// Dual-master L1 memory subsystem
module axi4_l1_mem_subsys #(
	parameter int MEM_WORDS = 4096
) (
	input logic clk,
	input logic rst,
	// ##############################
	// master 0
	// ##############################
	input logic m0_aw_valid,
	output logic m0_aw_ready,
	input axi4_pkg::axi4_aw_t m0_aw,
	input logic m0_w_valid,
	output logic m0_w_ready,
	input axi4_pkg::axi4_w_t m0_w,
	input logic m0_ar_valid,
	output logic m0_ar_ready,
	input axi4_pkg::axi4_ar_t m0_ar,
	output logic m0_b_valid,
	input logic m0_b_ready,
	output axi4_pkg::axi4_b_t m0_b,
	output logic m0_r_valid,
	input logic m0_r_ready,
	output axi4_pkg::axi4_r_t m0_r,
	// ##############################
	// master 1
	// ##############################
	input logic m1_aw_valid,
	output logic m1_aw_ready,
	input axi4_pkg::axi4_aw_t m1_aw,
	input logic m1_w_valid,
	output logic m1_w_ready,
	input axi4_pkg::axi4_w_t m1_w,
	input logic m1_ar_valid,
	output logic m1_ar_ready,
	input axi4_pkg::axi4_ar_t m1_ar,
	output logic m1_b_valid,
	input logic m1_b_ready,
	output axi4_pkg::axi4_b_t m1_b,
	output logic m1_r_valid,
	input logic m1_r_ready,
	output axi4_pkg::axi4_r_t m1_r
);
	import mem_pkg::*;

	logic [1:0] req_valid;
	logic [1:0] req_ready;
	mem_req_t req0;
	mem_req_t req1;
	logic sram_req_valid;
	mem_req_t sram_req;
	logic sram_rsp_valid;
	mem_rsp_t sram_rsp;
	logic [1:0] rsp_valid;
	mem_rsp_t rsp;

	axi4_slave_port #(.MEM_WORDS(MEM_WORDS)) u_port0 (
		.clk(clk), .rst(rst),
		.aw_valid(m0_aw_valid), .aw_ready(m0_aw_ready), .aw(m0_aw),
		.w_valid(m0_w_valid), .w_ready(m0_w_ready), .w(m0_w),
		.ar_valid(m0_ar_valid), .ar_ready(m0_ar_ready), .ar(m0_ar),
		.b_valid(m0_b_valid), .b_ready(m0_b_ready), .b(m0_b),
		.r_valid(m0_r_valid), .r_ready(m0_r_ready), .r(m0_r),
		.req_valid(req_valid[0]), .req_ready(req_ready[0]), .req(req0),
		.rsp_valid(rsp_valid[0]), .rsp(rsp)
	);

	axi4_slave_port #(.MEM_WORDS(MEM_WORDS)) u_port1 (
		.clk(clk), .rst(rst),
		.aw_valid(m1_aw_valid), .aw_ready(m1_aw_ready), .aw(m1_aw),
		.w_valid(m1_w_valid), .w_ready(m1_w_ready), .w(m1_w),
		.ar_valid(m1_ar_valid), .ar_ready(m1_ar_ready), .ar(m1_ar),
		.b_valid(m1_b_valid), .b_ready(m1_b_ready), .b(m1_b),
		.r_valid(m1_r_valid), .r_ready(m1_r_ready), .r(m1_r),
		.req_valid(req_valid[1]), .req_ready(req_ready[1]), .req(req1),
		.rsp_valid(rsp_valid[1]), .rsp(rsp)
	);

	mem_arbiter u_arbiter (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req0(req0), .req1(req1),
		.sram_req_valid(sram_req_valid), .sram_req(sram_req),
		.sram_rsp_valid(sram_rsp_valid), .sram_rsp(sram_rsp),
		.rsp_valid(rsp_valid), .rsp(rsp)
	);

	l1_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
		.clk(clk), .rst(rst),
		.req_valid(sram_req_valid), .req(sram_req),
		.rsp_valid(sram_rsp_valid), .rsp(sram_rsp)
	);

endmodule

//--- hw/axi4_pkg.sv
// AXI4 channel types
package axi4_pkg;

	// ##############################
	// field widths
	// ##############################

	localparam int AXI4_ADDRESS_WIDTH = 20;
	localparam int AXI4_DATA_WIDTH = 32;
	localparam int AXI4_ID_WIDTH = 4;
	localparam int AXI4_STRB_WIDTH = AXI4_DATA_WIDTH / 8;

	// the only response code this subsystem ever returns
	localparam logic [1:0] AXI4_RESP_OKAY = 2'b00;

	// ##############################
	// channel payloads
	// ##############################

	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0] id;
		logic [AXI4_ADDRESS_WIDTH-1:0] addr;
	} axi4_aw_t;

	// single-beat writes, so last is expected high on every beat
	typedef struct packed {
		logic [AXI4_DATA_WIDTH-1:0] data;
		logic [AXI4_STRB_WIDTH-1:0] strb;
		logic last;
	} axi4_w_t;

	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0] id;
		logic [AXI4_ADDRESS_WIDTH-1:0] addr;
	} axi4_ar_t;

	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0] id;
		logic [1:0] resp;
	} axi4_b_t;

	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0] id;
		logic [AXI4_DATA_WIDTH-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi4_r_t;

endpackage

//--- hw/axi4_slave_port.sv
// AXI4 slave port
module axi4_slave_port #(
	parameter int MEM_WORDS = 4096
) (
	input logic clk,
	input logic rst,
	input logic aw_valid,
	output logic aw_ready,
	input axi4_pkg::axi4_aw_t aw,
	input logic w_valid,
	output logic w_ready,
	input axi4_pkg::axi4_w_t w,
	input logic ar_valid,
	output logic ar_ready,
	input axi4_pkg::axi4_ar_t ar,
	output logic b_valid,
	input logic b_ready,
	output axi4_pkg::axi4_b_t b,
	output logic r_valid,
	input logic r_ready,
	output axi4_pkg::axi4_r_t r,
	output logic req_valid,
	input logic req_ready,
	output mem_pkg::mem_req_t req,
	input logic rsp_valid,
	input mem_pkg::mem_rsp_t rsp
);
	import axi4_pkg::*;
	import mem_pkg::*;

	axi4_aw_t aw_q;
	axi4_w_t w_q;
	axi4_ar_t ar_q;
	logic aw_q_valid;
	logic w_q_valid;
	logic ar_q_valid;
	logic wr_pend;
	logic rd_pend;
	logic pick_rd;
	logic req_fire;
	logic wr_pop;
	logic rd_pop;
	logic busy;
	logic last_rd;
	logic [AXI4_ID_WIDTH-1:0] rsp_id;
	logic [AXI4_DATA_WIDTH-1:0] rsp_data;

	// ##############################
	// input slices
	// ##############################

	axi4_chan_slice #(.payload_t(axi4_aw_t)) u_aw_slice (
		.clk(clk), .rst(rst),
		.in_valid(aw_valid), .in_ready(aw_ready), .in_data(aw),
		.out_valid(aw_q_valid), .out_ready(wr_pop), .out_data(aw_q)
	);

	axi4_chan_slice #(.payload_t(axi4_w_t)) u_w_slice (
		.clk(clk), .rst(rst),
		.in_valid(w_valid), .in_ready(w_ready), .in_data(w),
		.out_valid(w_q_valid), .out_ready(wr_pop), .out_data(w_q)
	);

	axi4_chan_slice #(.payload_t(axi4_ar_t)) u_ar_slice (
		.clk(clk), .rst(rst),
		.in_valid(ar_valid), .in_ready(ar_ready), .in_data(ar),
		.out_valid(ar_q_valid), .out_ready(rd_pop), .out_data(ar_q)
	);

	// ##############################
	// request side
	// ##############################

	// a write needs both its address and its data
	assign wr_pend = aw_q_valid && w_q_valid;
	assign rd_pend = ar_q_valid;
	// with both waiting, a read goes only if the previous request was a write
	assign pick_rd = rd_pend && (!wr_pend || !last_rd);
	assign req_valid = !busy && (wr_pend || rd_pend);
	assign req_fire = req_valid && req_ready;
	assign wr_pop = req_fire && !pick_rd;
	assign rd_pop = req_fire && pick_rd;

	always_comb begin
		if (pick_rd) begin
			req.addr = ar_q.addr[AXI4_ADDRESS_WIDTH-1 -: MEM_ADDR_WIDTH];
			req.we = 1'b0;
			req.data = '0;
			req.strb = '0;
			req.id = ar_q.id;
		end else begin
			req.addr = aw_q.addr[AXI4_ADDRESS_WIDTH-1 -: MEM_ADDR_WIDTH];
			req.we = 1'b1;
			req.data = w_q.data;
			req.strb = w_q.strb;
			req.id = aw_q.id;
		end
	end

	// ##############################
	// response side
	// ##############################

	// busy covers the whole trip from grant to the B or R handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			last_rd <= 1'b0;
			b_valid <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			if (req_fire) begin
				busy <= 1'b1;
				last_rd <= pick_rd;
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				busy <= 1'b0;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				busy <= 1'b0;
			end
			if (rsp_valid) begin
				b_valid <= rsp.write;
				r_valid <= !rsp.write;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_valid) begin
			rsp_id <= rsp.id;
			rsp_data <= rsp.data;
		end
	end

	assign b.id = rsp_id;
	assign b.resp = AXI4_RESP_OKAY;
	assign r.id = rsp_id;
	assign r.data = rsp_data;
	assign r.resp = AXI4_RESP_OKAY;
	assign r.last = 1'b1;

	// masters issue single beats only
	assert property (@(posedge clk) disable iff (rst) w_valid |-> w.last);

	// addresses from the master must fall inside the SRAM
	assert property (@(posedge clk) disable iff (rst)
		req_valid |-> req.addr < MEM_WORDS);

endmodule

//--- hw/l1_sram.sv
// Single-port SRAM with byte strobes
module l1_sram #(
	parameter int MEM_WORDS = 4096
) (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input mem_pkg::mem_req_t req,
	output logic rsp_valid,
	output mem_pkg::mem_rsp_t rsp
);
	import axi4_pkg::*;

	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	logic [AXI4_DATA_WIDTH-1:0] mem [MEM_WORDS];
	logic [IDX_WIDTH-1:0] idx;

	assign idx = req.addr[IDX_WIDTH-1:0];

	// read-first, a write returns the old word which the port ignores
	always_ff @(posedge clk) begin
		if (req_valid) begin
			if (req.we) begin
				for (int i = 0; i < AXI4_STRB_WIDTH; i++) begin
					if (req.strb[i]) begin
						mem[idx][8*i +: 8] <= req.data[8*i +: 8];
					end
				end
			end
			rsp.data <= mem[idx];
			rsp.write <= req.we;
			rsp.id <= req.id;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= req_valid;
		end
	end

endmodule

//--- hw/mem_arbiter.sv
// Round-robin memory arbiter
module mem_arbiter (
	input logic clk,
	input logic rst,
	input logic [1:0] req_valid,
	output logic [1:0] req_ready,
	input mem_pkg::mem_req_t req0,
	input mem_pkg::mem_req_t req1,
	output logic sram_req_valid,
	output mem_pkg::mem_req_t sram_req,
	input logic sram_rsp_valid,
	input mem_pkg::mem_rsp_t sram_rsp,
	output logic [1:0] rsp_valid,
	output mem_pkg::mem_rsp_t rsp
);
	import mem_pkg::*;

	master_idx_t prio;
	master_idx_t sel;
	master_idx_t rsp_tag;

	// ##############################
	// grant
	// ##############################

	// prio only matters when both ports ask in the same cycle
	always_comb begin
		if (req_valid[0] && req_valid[1]) begin
			sel = prio;
		end else if (req_valid[1]) begin
			sel = 1'b1;
		end else begin
			sel = 1'b0;
		end
	end

	assign req_ready[0] = (sel == 1'b0);
	assign req_ready[1] = (sel == 1'b1);
	assign sram_req_valid = |req_valid;
	assign sram_req = sel ? req1 : req0;

	always_ff @(posedge clk) begin
		if (rst) begin
			prio <= 1'b0;
		end else if (sram_req_valid) begin
			prio <= !sel;
		end
	end

	// ##############################
	// response routing
	// ##############################

	// the SRAM answers one cycle later, so one tag covers the request in flight
	always_ff @(posedge clk) begin
		if (sram_req_valid) begin
			rsp_tag <= sel;
		end
	end

	assign rsp_valid[0] = sram_rsp_valid && (rsp_tag == 1'b0);
	assign rsp_valid[1] = sram_rsp_valid && (rsp_tag == 1'b1);
	assign rsp = sram_rsp;

	assert property (@(posedge clk) disable iff (rst) $onehot0(req_valid & req_ready));

	// every granted request must come back on the next cycle for the tag to hold
	assert property (@(posedge clk) disable iff (rst) sram_req_valid |=> sram_rsp_valid);

endmodule

//--- hw/mem_pkg.sv
// Shared memory request types
package mem_pkg;

	// word address, the byte offset inside a data word is dropped
	localparam int MEM_ADDR_WIDTH =
		axi4_pkg::AXI4_ADDRESS_WIDTH - $clog2(axi4_pkg::AXI4_STRB_WIDTH);

	// number of the master that owns a request
	typedef logic master_idx_t;

	// ##############################
	// request and response
	// ##############################

	typedef struct packed {
		logic [MEM_ADDR_WIDTH-1:0] addr;
		logic we;
		logic [axi4_pkg::AXI4_DATA_WIDTH-1:0] data;
		logic [axi4_pkg::AXI4_STRB_WIDTH-1:0] strb;
		logic [axi4_pkg::AXI4_ID_WIDTH-1:0] id;
	} mem_req_t;

	// write tells the port whether to answer on B or on R
	typedef struct packed {
		logic write;
		logic [axi4_pkg::AXI4_ID_WIDTH-1:0] id;
		logic [axi4_pkg::AXI4_DATA_WIDTH-1:0] data;
	} mem_rsp_t;

endpackage

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f sources.f \
	--top-module axi4_l1_mem_subsys_tb &&
./obj_dir/Vaxi4_l1_mem_subsys_tb | tee /dev/stderr | grep -q "^Testbench passed$" ||
exit 1

//--- sources.f
hw/axi4_pkg.sv
hw/mem_pkg.sv
hw/axi4_chan_slice.sv
hw/axi4_slave_port.sv
hw/mem_arbiter.sv
hw/l1_sram.sv
hw/axi4_l1_mem_subsys.sv
testbench/axi4_tb_master.sv
testbench/axi4_l1_mem_subsys_tb.sv

//--- testbench/axi4_l1_mem_subsys_tb.sv
// Memory subsystem testbench
module axi4_l1_mem_subsys_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import axi4_pkg::*;
	import mem_pkg::*;

	localparam int MEM_WORDS = 4096;
	localparam int WINDOW = 64;
	localparam int PHASE_A_COUNT = 150;
	localparam int PHASE_B_COUNT = 60;
	localparam int TOTAL_TXNS = 2 * (PHASE_A_COUNT + PHASE_B_COUNT);
	localparam int CYCLE_LIMIT = TOTAL_TXNS * 40;
	localparam int FAIR_WINDOW = 40;

	logic clk;
	logic rst;
	logic aw_valid [2];
	logic aw_ready [2];
	axi4_aw_t aw [2];
	logic w_valid [2];
	logic w_ready [2];
	axi4_w_t w [2];
	logic ar_valid [2];
	logic ar_ready [2];
	axi4_ar_t ar [2];
	logic b_valid [2];
	logic b_ready [2];
	axi4_b_t b [2];
	logic r_valid [2];
	logic r_ready [2];
	axi4_r_t r [2];
	logic start [2];
	logic done [2];
	int unsigned base [2];
	int unsigned span;
	int unsigned count;
	logic cpl_valid [2];
	mem_req_t cpl_req [2];
	mem_rsp_t cpl_rsp [2];
	// reference copy of the window, a known bit per byte once it was written
	logic [AXI4_DATA_WIDTH-1:0] ref_mem [WINDOW] = '{default: '0};
	logic [AXI4_STRB_WIDTH-1:0] ref_known [WINDOW] = '{default: '0};
	int unsigned issued [2] = '{0, 0};
	int unsigned responses [2] = '{0, 0};
	int unsigned idle [2] = '{0, 0};
	int unsigned cycles = 0;
	int errors = 0;
	logic quiet;
	logic fair_check;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	axi4_l1_mem_subsys #(.MEM_WORDS(MEM_WORDS)) u_dut (
		.clk(clk), .rst(rst),
		.m0_aw_valid(aw_valid[0]), .m0_aw_ready(aw_ready[0]), .m0_aw(aw[0]),
		.m0_w_valid(w_valid[0]), .m0_w_ready(w_ready[0]), .m0_w(w[0]),
		.m0_ar_valid(ar_valid[0]), .m0_ar_ready(ar_ready[0]), .m0_ar(ar[0]),
		.m0_b_valid(b_valid[0]), .m0_b_ready(b_ready[0]), .m0_b(b[0]),
		.m0_r_valid(r_valid[0]), .m0_r_ready(r_ready[0]), .m0_r(r[0]),
		.m1_aw_valid(aw_valid[1]), .m1_aw_ready(aw_ready[1]), .m1_aw(aw[1]),
		.m1_w_valid(w_valid[1]), .m1_w_ready(w_ready[1]), .m1_w(w[1]),
		.m1_ar_valid(ar_valid[1]), .m1_ar_ready(ar_ready[1]), .m1_ar(ar[1]),
		.m1_b_valid(b_valid[1]), .m1_b_ready(b_ready[1]), .m1_b(b[1]),
		.m1_r_valid(r_valid[1]), .m1_r_ready(r_ready[1]), .m1_r(r[1])
	);

	for (genvar i = 0; i < 2; i++) begin : g_master
		axi4_tb_master u_master (
			.clk(clk), .start(start[i]), .base(base[i]), .span(span), .count(count),
			.done(done[i]),
			.aw_valid(aw_valid[i]), .aw_ready(aw_ready[i]), .aw(aw[i]),
			.w_valid(w_valid[i]), .w_ready(w_ready[i]), .w(w[i]),
			.ar_valid(ar_valid[i]), .ar_ready(ar_ready[i]), .ar(ar[i]),
			.b_valid(b_valid[i]), .b_ready(b_ready[i]), .b(b[i]),
			.r_valid(r_valid[i]), .r_ready(r_ready[i]), .r(r[i]),
			.cpl_valid(cpl_valid[i]), .cpl_req(cpl_req[i]), .cpl_rsp(cpl_rsp[i])
		);
	end

	// ##############################
	// reference model and checks
	// ##############################

	// strobe bit n enables data byte n
	function automatic logic [AXI4_DATA_WIDTH-1:0] byte_mask(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	task automatic check_completion(input master_idx_t m);
		mem_req_t req;
		mem_rsp_t rsp;
		logic [5:0] a;
		logic [AXI4_DATA_WIDTH-1:0] known;
		req = cpl_req[m];
		rsp = cpl_rsp[m];
		a = req.addr[5:0];
		assert (rsp.write == req.we && rsp.id == req.id) else begin
			errors++;
			$display("Error at %0d ns: master %0d response write %0b id %h, expected write %0b id %h",
				$time, m, rsp.write, rsp.id, req.we, req.id);
		end
		if (req.we) begin
			ref_mem[a] = (ref_mem[a] & ~byte_mask(req.strb)) | (req.data & byte_mask(req.strb));
			ref_known[a] = ref_known[a] | req.strb;
		end else begin
			// bytes never written hold no defined value and are skipped
			known = byte_mask(ref_known[a]);
			assert ((rsp.data & known) == (ref_mem[a] & known)) else begin
				errors++;
				$display("Error at %0d ns: master %0d read word %0d got %h, expected %h mask %h",
					$time, m, a, rsp.data, ref_mem[a], known);
			end
		end
	endtask

	task automatic watch_master(input master_idx_t m);
		if ((aw_valid[m] && aw_ready[m]) || (ar_valid[m] && ar_ready[m])) begin
			issued[m]++;
		end
		if ((b_valid[m] && b_ready[m]) || (r_valid[m] && r_ready[m])) begin
			responses[m]++;
		end
		if (quiet) begin
			assert (!b_valid[m] && !r_valid[m]) else begin
				errors++;
				$display("Error at %0d ns: master %0d sees a response before any request",
					$time, m);
			end
		end
		// every single-beat response is OKAY and is also the last beat
		if (b_valid[m]) begin
			assert (b[m].resp == 2'b00) else begin
				errors++;
				$display("Error at %0d ns: master %0d B resp %b, expected OKAY",
					$time, m, b[m].resp);
			end
		end
		if (r_valid[m]) begin
			assert (r[m].resp == 2'b00 && r[m].last) else begin
				errors++;
				$display("Error at %0d ns: master %0d R resp %b last %0b, expected OKAY last 1",
					$time, m, r[m].resp, r[m].last);
			end
		end
		if (cpl_valid[m]) begin
			check_completion(m);
		end
		// cycles since the last completion, while both masters keep issuing
		if (fair_check && !done[m]) begin
			idle[m] = cpl_valid[m] ? 0 : idle[m] + 1;
			assert (idle[m] <= FAIR_WINDOW) else begin
				errors++;
				$display("Error at %0d ns: master %0d went %0d cycles without a completion",
					$time, m, idle[m]);
			end
		end else begin
			idle[m] = 0;
		end
	endtask

	task automatic check_totals(input master_idx_t m);
		assert (issued[m] == responses[m] && responses[m] == PHASE_A_COUNT + PHASE_B_COUNT)
		else begin
			errors++;
			$display("Error at %0d ns: master %0d issued %0d and completed %0d, expected %0d",
				$time, m, issued[m], responses[m], PHASE_A_COUNT + PHASE_B_COUNT);
		end
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			watch_master(1'b0);
			watch_master(1'b1);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the transactions did not all complete", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ##############################
	// stimulus
	// ##############################

	task automatic to_drive_point();
		@(posedge clk);
		#0.5;
	endtask

	task automatic run_masters(input logic [1:0] which, input int unsigned n);
		count = n;
		start[0] = which[0];
		start[1] = which[1];
		do begin
			@(negedge clk);
		end while ((which[0] && !done[0]) || (which[1] && !done[1]));
		to_drive_point();
		start[0] = 1'b0;
		start[1] = 1'b0;
		do begin
			@(negedge clk);
		end while (done[0] || done[1]);
		to_drive_point();
	endtask

	initial begin
		void'($urandom(32'h3db1));
		rst = 1'b1;
		quiet = 1'b0;
		fair_check = 1'b0;
		start[0] = 1'b0;
		start[1] = 1'b0;
		base[0] = 0;
		base[1] = 0;
		span = WINDOW;
		count = 0;
		repeat (4) @(posedge clk);
		#0.5;
		rst = 1'b0;
		quiet = 1'b1;
		repeat (4) to_drive_point();
		quiet = 1'b0;
		// both masters at once, each in its own half of the window
		base[1] = WINDOW / 2;
		span = WINDOW / 2;
		fair_check = 1'b1;
		run_masters(2'b11, PHASE_A_COUNT);
		fair_check = 1'b0;
		// whole window shared, one master after the other
		base[1] = 0;
		span = WINDOW;
		run_masters(2'b01, PHASE_B_COUNT);
		run_masters(2'b10, PHASE_B_COUNT);
		repeat (10) to_drive_point();
		check_totals(1'b0);
		check_totals(1'b1);
		$display("Completed %0d and %0d transactions, %0d errors",
			responses[0], responses[1], errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- testbench/axi4_tb_master.sv
// AXI4 master model
module axi4_tb_master (
	input logic clk,
	input logic start,
	input int unsigned base,
	input int unsigned span,
	input int unsigned count,
	output logic done,
	output logic aw_valid,
	input logic aw_ready,
	output axi4_pkg::axi4_aw_t aw,
	output logic w_valid,
	input logic w_ready,
	output axi4_pkg::axi4_w_t w,
	output logic ar_valid,
	input logic ar_ready,
	output axi4_pkg::axi4_ar_t ar,
	input logic b_valid,
	output logic b_ready,
	input axi4_pkg::axi4_b_t b,
	input logic r_valid,
	output logic r_ready,
	input axi4_pkg::axi4_r_t r,
	output logic cpl_valid,
	output mem_pkg::mem_req_t cpl_req,
	output mem_pkg::mem_rsp_t cpl_rsp
);
	timeunit 1ns;
	timeprecision 100ps;
	import mem_pkg::*;

	task automatic to_drive_point();
		@(posedge clk);
		#0.5;
	endtask

	// ##############################
	// transactions
	// ##############################

	// one transaction at a time, each one reported after its B or R handshake
	initial begin
		mem_req_t req;
		mem_rsp_t got;
		logic [31:0] rnd;
		logic [31:0] word_addr;
		logic aw_take;
		logic w_take;
		logic ar_take;
		aw_valid = 1'b0;
		w_valid = 1'b0;
		ar_valid = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		done = 1'b0;
		cpl_valid = 1'b0;
		cpl_req = '0;
		cpl_rsp = '0;
		forever begin
			do begin
				@(negedge clk);
			end while (!start);
			for (int unsigned n = 0; n < count; n++) begin
				to_drive_point();
				cpl_valid = 1'b0;
				repeat ($urandom % 3) to_drive_point();
				rnd = $urandom;
				word_addr = base + ($urandom % span);
				req.addr = word_addr[MEM_ADDR_WIDTH-1:0];
				req.we = rnd[0];
				req.strb = rnd[4:1];
				req.id = rnd[8:5];
				req.data = $urandom;
				aw.id = req.id;
				aw.addr = {req.addr, 2'b00};
				w.data = req.data;
				w.strb = req.strb;
				w.last = 1'b1;
				ar.id = req.id;
				ar.addr = {req.addr, 2'b00};
				aw_valid = req.we;
				w_valid = req.we;
				ar_valid = !req.we;
				// aw and w may be taken on different edges
				while (aw_valid || w_valid || ar_valid) begin
					@(negedge clk);
					aw_take = aw_valid && aw_ready;
					w_take = w_valid && w_ready;
					ar_take = ar_valid && ar_ready;
					to_drive_point();
					aw_valid = aw_valid && !aw_take;
					w_valid = w_valid && !w_take;
					ar_valid = ar_valid && !ar_take;
				end
				do begin
					@(negedge clk);
				end while (!(b_valid && b_ready) && !(r_valid && r_ready));
				got.write = b_valid && b_ready;
				got.id = got.write ? b.id : r.id;
				got.data = r.data;
				to_drive_point();
				cpl_req = req;
				cpl_rsp = got;
				cpl_valid = 1'b1;
			end
			to_drive_point();
			cpl_valid = 1'b0;
			done = 1'b1;
			do begin
				@(negedge clk);
			end while (start);
			to_drive_point();
			done = 1'b0;
		end
	end

	// random back-pressure on B and R, never low for more than five cycles in a row
	initial begin
		int unsigned b_low;
		int unsigned r_low;
		b_low = 0;
		r_low = 0;
		b_ready = 1'b0;
		r_ready = 1'b0;
		forever begin
			to_drive_point();
			b_ready = (b_low >= 5) || ($urandom % 4 != 0);
			r_ready = (r_low >= 5) || ($urandom % 4 != 0);
			b_low = b_ready ? 0 : b_low + 1;
			r_low = r_ready ? 0 : r_low + 1;
		end
	end

endmodule
